// File: files.f
verilog/sd_isa_pkg.sv
verilog/sd_link_pkg.sv
verilog/sd_microcode_rom.sv
verilog/sd_accumulator.sv
verilog/spi_byte_engine.sv
verilog/sd_sequencer.sv
verilog/sd_spi_reader.sv
tests/sd_checker.sv
tests/sd_spi_reader_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sd_spi_reader testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module sd_spi_reader_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0

// File: tests/sd_checker.sv
module sd_checker (
    input  logic                      iclk,
    input  logic                      en,
    input  logic                      req_valid,
    input  logic                      req_ready,
    input  logic                      byte_valid,
    output logic                      byte_ready,
    input  sd_link_pkg::sector_byte_t byte_out,
    input  logic                      spi_cs,
    input  logic                      spi_clk,
    input  logic                      spi_mosi,
    input  logic [7:0]                exp_base,
    input  logic [31:0]               exp_addr,
    input  logic                      addr_known,
    input  int                        cmd17_cnt,
    input  logic [31:0]               cmd17_arg,
    output int                        err_count
);
    import sd_link_pkg::*;

    int           seed = 61;
    int           rnd;
    int           errors = 0;
    logic         ready_q = 1'b0;
    int           idx_next = 0;
    logic         open_blk = 1'b1;      // init reads one block on its own
    logic         stalled = 1'b0;
    sector_byte_t held;
    int           half_cnt = 0;
    logic         prev_clk = 1'b0;
    logic         prev_rr = 1'b0;
    logic         slow_seen = 1'b0;
    logic         fast_seen = 1'b0;
    logic         init_done = 1'b0;
    int           cmd17_seen = 0;
    int           cmd17_mark = 0;

    assign byte_ready = ready_q;
    assign err_count  = errors;

    task automatic flag_error(input string msg);
        $display("ERR %0t %s", $time, msg);
        errors++;
    endtask

    task automatic check_stream();
        logic [7:0] want;
        want = exp_base + idx_next[7:0];    // card data is base plus index
        if (stalled && (!byte_valid || byte_out != held))
            flag_error($sformatf("payload moved while waiting, %h to %h", held, byte_out));
        if (byte_valid && ready_q)
        begin
            if (!open_blk || idx_next > 511)
                flag_error($sformatf("byte idx %0d outside any block", byte_out.idx));
            else if (byte_out.idx != idx_next[8:0] || byte_out.data != want)
                flag_error($sformatf("byte %0d got idx %0d data %h, expected data %h",
                    idx_next, byte_out.idx, byte_out.data, want));
            idx_next++;
        end
        stalled = byte_valid && !ready_q;
        held    = byte_out;
    endtask

    task automatic check_spi_clock();
        half_cnt++;
        if (spi_clk != prev_clk)
        begin
            if (!spi_clk)   // a high phase never spans two bytes
            begin
                if (!init_done && !fast_seen && half_cnt == int'(DIV_SLOW) + 1)
                    slow_seen = 1'b1;
                else if (!init_done && slow_seen && half_cnt == int'(DIV_FAST) + 1)
                    fast_seen = 1'b1;
                else if (init_done && half_cnt != int'(DIV_FAST) + 1)
                    flag_error($sformatf("fast half period %0d cycles", half_cnt));
                else if (!init_done)
                    flag_error($sformatf("init half period %0d cycles", half_cnt));
            end
            half_cnt = 0;
            prev_clk = spi_clk;
        end
    endtask

    task automatic check_request();
        if (cmd17_cnt != cmd17_seen)
        begin
            cmd17_seen = cmd17_cnt;
            if (addr_known && cmd17_arg != exp_addr)
                flag_error($sformatf("cmd17 address %h, expected %h", cmd17_arg, exp_addr));
        end
        if (req_ready && !prev_rr && open_blk)
        begin
            if (idx_next != 512)
                flag_error($sformatf("block ended after %0d bytes", idx_next));
            if (addr_known && cmd17_seen != cmd17_mark + 1)
                flag_error($sformatf("%0d cmd17 for one request", cmd17_seen - cmd17_mark));
            open_blk  = 1'b0;
            init_done = 1'b1;
        end
        if (req_valid && req_ready)
        begin
            open_blk   = 1'b1;
            idx_next   = 0;
            cmd17_mark = cmd17_seen;
        end
        prev_rr = req_ready;
    endtask

    always @(posedge iclk)
    begin
        if (!en)
        begin
            if (spi_cs !== 1'b1 || spi_clk !== 1'b0 || spi_mosi !== 1'b1)
                flag_error("spi pins not idle in reset");
            if (req_ready !== 1'b0 || byte_valid !== 1'b0)
                flag_error("handshake outputs high in reset");
            ready_q <= 1'b0;
        end
        else
        begin
            check_stream();
            check_spi_clock();
            check_request();
            rnd = $random(seed);
            ready_q <= rnd[0];      // random back-pressure
        end
    end

endmodule

// File: tests/sd_spi_reader_tb.sv
module sd_spi_reader_tb;
    import sd_link_pkg::*;

    localparam int MAX_REQ        = 32;
    localparam int INIT_TIMEOUT   = 400000;
    localparam int SECTOR_TIMEOUT = 80000;
    localparam int ACCEPT_TIMEOUT = 100;

    logic         iclk = 1'b0;
    logic         en;
    logic         req_valid;
    logic         req_ready;
    sd_req_t      req;
    logic         byte_valid;
    logic         byte_ready;
    sector_byte_t byte_out;
    logic         spi_cs;
    logic         spi_clk;
    logic         spi_mosi;
    logic         spi_miso = 1'b1;

    logic [39:0]  tests [MAX_REQ];  // address, base byte
    logic [7:0]   exp_base;
    logic [31:0]  exp_addr;
    logic         addr_known;
    int           err_count;
    int           timeouts = 0;

    logic [7:0]   card_rx = 8'hff;
    logic [7:0]   card_tx = 8'hff;
    logic [3:0]   card_bits = 4'd0;
    logic [7:0]   cmd_buf [6];
    logic [2:0]   cmd_len = 3'd0;
    logic         app_cmd = 1'b0;
    int           acmd41_cnt = 0;
    logic [7:0]   resp_q [$];
    int           cmd17_cnt = 0;
    logic [31:0]  cmd17_arg = '0;

    always #4 iclk = ~iclk;

    sd_spi_reader sd_spi_reader_i (
        .iclk       (iclk),
        .en         (en),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .byte_out   (byte_out),
        .spi_cs     (spi_cs),
        .spi_clk    (spi_clk),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    sd_checker sd_checker_i (
        .iclk       (iclk),
        .en         (en),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .byte_out   (byte_out),
        .spi_cs     (spi_cs),
        .spi_clk    (spi_clk),
        .spi_mosi   (spi_mosi),
        .exp_base   (exp_base),
        .exp_addr   (exp_addr),
        .addr_known (addr_known),
        .cmd17_cnt  (cmd17_cnt),
        .cmd17_arg  (cmd17_arg),
        .err_count  (err_count)
    );

    task automatic answer_command();
        int i;
        case (cmd_buf[0][5:0])
        6'd0:  resp_q.push_back(8'h01);
        6'd8:
        begin
            resp_q.push_back(8'h01);
            repeat (4)
                resp_q.push_back(8'hff);    // r7 tail
        end
        6'd55: resp_q.push_back(8'h01);
        6'd41:
            if (app_cmd)
            begin
                resp_q.push_back(acmd41_cnt == 0 ? 8'h01 : 8'h00);
                acmd41_cnt++;
            end
        6'd17:
        begin
            cmd17_arg = {cmd_buf[1], cmd_buf[2], cmd_buf[3], cmd_buf[4]};
            cmd17_cnt++;
            resp_q.push_back(8'h00);
            resp_q.push_back(8'hff);
            resp_q.push_back(8'hff);
            resp_q.push_back(8'hfe);        // start token
            for (i = 0; i < 512; i++)
                resp_q.push_back(exp_base + i[7:0]);
            resp_q.push_back(8'h5a);        // crc, not checked
            resp_q.push_back(8'ha5);
        end
        default: ;
        endcase
        app_cmd = (cmd_buf[0][5:0] == 6'd55);
    endtask

    task automatic take_byte(input logic [7:0] b);
        if (!spi_cs && (cmd_len != 3'd0 || b[7:6] == 2'b01))
        begin
            cmd_buf[cmd_len] = b;
            cmd_len = cmd_len + 3'd1;
            if (cmd_len == 3'd6)
            begin
                cmd_len = 3'd0;
                answer_command();
            end
        end
    endtask

    // card side of spi mode 0
    always @(posedge spi_clk or negedge spi_clk)
    begin
        if (spi_clk)
        begin
            card_rx = {card_rx[6:0], spi_mosi};
            card_bits = card_bits + 4'd1;
            if (card_bits == 4'd8)
            begin
                card_bits = 4'd0;
                take_byte(card_rx);
            end
        end
        else
        begin
            if (card_bits != 4'd0)
                card_tx = {card_tx[6:0], 1'b1};
            else if (resp_q.size() > 0)
                card_tx = resp_q.pop_front();
            else
                card_tx = 8'hff;
            spi_miso = card_tx[7];
        end
    end

    task automatic wait_for_ready(input int limit, input string what, inout logic ok);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge iclk);
            cycles++;
        end
        while (!req_ready && cycles < limit);
        if (!req_ready)
        begin
            $display("timeout: req_ready stayed low after %s for %0d cycles", what, limit);
            timeouts++;
            ok = 1'b0;
        end
    endtask

    task automatic wait_for_accept(inout logic ok);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge iclk);
            cycles++;
        end
        while (!req_ready && cycles < ACCEPT_TIMEOUT);
        if (!req_ready)
        begin
            $display("timeout: request was not accepted within %0d cycles", ACCEPT_TIMEOUT);
            timeouts++;
            ok = 1'b0;
        end
    endtask

    initial
    begin
        int   n;
        logic ok;
        ok         = 1'b1;
        en         = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        exp_base   = '0;    // the init block reads with base zero
        exp_addr   = '0;
        addr_known = 1'b0;
        for (n = 0; n < MAX_REQ; n++)
            tests[n[4:0]] = '0;
        $readmemh("tests/sd_tests.mem", tests);
        n = 0;
        @(posedge iclk);
        en <= 1'b0;
        repeat (5)
            @(posedge iclk);
        en <= 1'b1;
        wait_for_ready(INIT_TIMEOUT, "card init", ok);
        while (ok && n < MAX_REQ && tests[n[4:0]] != '0)
        begin
            exp_addr   <= tests[n[4:0]][39:8];
            exp_base   <= tests[n[4:0]][7:0];
            addr_known <= 1'b1;
            req.addr   <= tests[n[4:0]][39:8];
            req_valid  <= 1'b1;
            wait_for_accept(ok);
            req_valid  <= 1'b0;
            if (ok)
                wait_for_ready(SECTOR_TIMEOUT, "a sector", ok);
            n++;
        end
        repeat (4)
            @(posedge iclk);
        $display("requests %0d, check errors %0d, timeouts %0d", n, err_count, timeouts);
        if (ok && err_count == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: tests/sd_tests.mem
// columns: block address (32 bit hex) _ data base byte (8 bit hex)
// one request per line, a line of all zeros ends the list
00000001_10
0000a5c3_7f
12345678_e1
00ff00ff_00
deadbeef_55
80000000_fe
0001e240_3c
7fffffff_81
00000200_c7
fedcba98_09
00000000_00

// File: verilog/sd_accumulator.sv
module sd_accumulator (
    input  logic                   iclk,
    input  logic                   en,
    input  sd_isa_pkg::acc_ctl_t   acc_cmd,
    input  sd_isa_pkg::acc_t       imm,
    input  sd_link_pkg::spi_byte_t load_byte,
    output sd_isa_pkg::acc_t       acc,
    output logic                   acc_zero,
    output logic                   acc_neg,
    output sd_link_pkg::spi_byte_t sr_rd
);
    import sd_isa_pkg::*;

    logic [7:0]          sr [SR_COUNT];
    logic [SR_IDX_W-1:0] sr_idx;

    assign sr_idx = imm[SR_IDX_W-1:0];

    always_ff @(posedge iclk or negedge en)
    begin
        if (!en)
            acc <= '0;
        else if (acc_cmd.acc_we)
        begin
            case (acc_cmd.op)
            add:     acc <= acc + imm;
            mov:     acc <= imm;
            stb:     acc <= acc | imm;
            rsb:     acc <= acc & ~imm;
            rsr:     acc <= acc_t'(sr[sr_idx]);
            ra:      acc <= {{4{load_byte[7]}}, load_byte};  // sign extend
            default: acc <= acc;
            endcase
        end
    end

    always_ff @(posedge iclk)
    begin
        if (acc_cmd.sr_we)
            sr[sr_idx] <= acc_cmd.sr_from_load ? load_byte : acc[7:0];
    end

    assign acc_zero = (acc == '0);
    assign acc_neg  = acc[ACC_W-1];
    assign sr_rd    = sr[sr_idx];

    // the program and the request path must only address existing registers
    assert property (@(posedge iclk) disable iff (!en)
        acc_cmd.sr_we |-> imm < SR_COUNT);

endmodule

// File: verilog/sd_isa_pkg.sv
package sd_isa_pkg;

    localparam int OP_W     = 4;
    localparam int PC_W     = 12;
    localparam int ACC_W    = 12;
    localparam int SR_COUNT = 8;
    localparam int SR_IDX_W = 3;
    localparam int SR_ADDR0 = 0;    // sr[0..3] hold the block address, msb first

    typedef enum logic [OP_W-1:0] {
        jnz = 4'h0,     // jump if acc != 0
        js  = 4'h1,     // jump if acc negative
        add = 4'h2,
        mov = 4'h3,
        tx  = 4'h4,     // send imm
        ta  = 4'h5,     // send acc
        lt  = 4'h6,     // send sr[imm]
        ra  = 4'h7,     // receive into acc, sign extended
        rs  = 4'h8,     // receive and stream out
        cs  = 4'h9,     // toggle chip select
        stb = 4'ha,     // acc |= imm
        rsb = 4'hb,     // acc &= ~imm
        wsr = 4'hc,     // sr[imm] = acc
        rsr = 4'hd,     // acc = sr[imm]
        ccd = 4'he,     // fast spi clock
        hlt = 4'hf      // wait for request
    } opcode_t;

    typedef logic [PC_W-1:0]  pc_t;
    typedef logic [ACC_W-1:0] acc_t;

    typedef struct packed {
        acc_t    imm;
        opcode_t op;
    } inst_t;

    typedef struct packed {
        opcode_t op;
        logic    acc_we;
        logic    sr_we;
        logic    sr_from_load;  // sr write data from load byte, else acc
    } acc_ctl_t;

    typedef struct packed {
        acc_ctl_t   ctl;
        acc_t       imm;
        logic [7:0] load_byte;
    } acc_cmd_t;

endpackage

// File: verilog/sd_link_pkg.sv
package sd_link_pkg;

    typedef logic [7:0] spi_byte_t;
    typedef logic [7:0] div_t;
    typedef logic [8:0] sector_idx_t;

    localparam div_t DIV_SLOW = 8'd128;   // init clock, well under 400 kHz
    localparam div_t DIV_FAST = 8'd3;

    typedef struct packed {
        logic [31:0] addr;      // block address
    } sd_req_t;

    typedef struct packed {
        sector_idx_t idx;
        spi_byte_t   data;
    } sector_byte_t;

endpackage

// File: verilog/sd_microcode_rom.sv
module sd_microcode_rom (
    input  sd_isa_pkg::pc_t   addr,
    output sd_isa_pkg::inst_t inst
);
    import sd_isa_pkg::*;

    always_comb
    begin
        case (addr)
        // clock sync, ten idle bytes
        12'h000: inst = {12'h00a, mov};
        12'h001: inst = {12'h0ff, tx};     // sync_loop
        12'h002: inst = {12'hfff, add};
        12'h003: inst = {12'h001, jnz};
        // cmd0, go idle
        12'h004: inst = {12'h000, cs};
        12'h005: inst = {12'h040, tx};
        12'h006: inst = {12'h000, tx};
        12'h007: inst = {12'h000, tx};
        12'h008: inst = {12'h000, tx};
        12'h009: inst = {12'h000, tx};
        12'h00a: inst = {12'h095, tx};
        12'h00b: inst = {12'h000, ra};     // cmd0_r1, wait for 0x01
        12'h00c: inst = {12'hfff, add};
        12'h00d: inst = {12'h00b, jnz};
        12'h00e: inst = {12'h000, cs};
        12'h00f: inst = {12'h0ff, tx};
        // cmd8, interface condition
        12'h010: inst = {12'h000, cs};
        12'h011: inst = {12'h048, tx};
        12'h012: inst = {12'h000, tx};
        12'h013: inst = {12'h000, tx};
        12'h014: inst = {12'h001, tx};
        12'h015: inst = {12'h0aa, tx};
        12'h016: inst = {12'h087, tx};
        12'h017: inst = {12'h000, ra};     // cmd8_r1
        12'h018: inst = {12'hfff, add};
        12'h019: inst = {12'h017, jnz};
        12'h01a: inst = {12'h0ff, tx};     // r7 tail, discarded
        12'h01b: inst = {12'h0ff, tx};
        12'h01c: inst = {12'h0ff, tx};
        12'h01d: inst = {12'h0ff, tx};
        12'h01e: inst = {12'h000, cs};
        12'h01f: inst = {12'h0ff, tx};
        // cmd55
        12'h020: inst = {12'h000, cs};     // app_loop
        12'h021: inst = {12'h077, tx};
        12'h022: inst = {12'h000, tx};
        12'h023: inst = {12'h000, tx};
        12'h024: inst = {12'h000, tx};
        12'h025: inst = {12'h000, tx};
        12'h026: inst = {12'h065, tx};
        12'h027: inst = {12'h000, ra};     // cmd55_r1
        12'h028: inst = {12'hfff, add};
        12'h029: inst = {12'h027, jnz};
        12'h02a: inst = {12'h000, cs};
        12'h02b: inst = {12'h0ff, tx};
        // acmd41 with hcs
        12'h02c: inst = {12'h000, cs};
        12'h02d: inst = {12'h069, tx};
        12'h02e: inst = {12'h040, tx};
        12'h02f: inst = {12'h000, tx};
        12'h030: inst = {12'h000, tx};
        12'h031: inst = {12'h000, tx};
        12'h032: inst = {12'h077, tx};
        12'h033: inst = {12'h000, ra};     // acmd41_r1
        12'h034: inst = {12'h033, js};
        12'h035: inst = {12'h0ff, tx};
        12'h036: inst = {12'h0ff, tx};
        12'h037: inst = {12'h0ff, tx};
        12'h038: inst = {12'h0ff, tx};
        12'h039: inst = {12'h000, cs};
        12'h03a: inst = {12'h0ff, tx};
        12'h03b: inst = {12'h020, jnz};    // still idle, retry app_loop
        // fast clock, mark card ready
        12'h03c: inst = {12'h000, ccd};
        12'h03d: inst = {12'h001, mov};
        12'h03e: inst = {12'h004, wsr};
        // cmd17, single block read
        12'h03f: inst = {12'h000, cs};     // read_block
        12'h040: inst = {12'h051, tx};
        12'h041: inst = {12'h000, rsr};
        12'h042: inst = {12'h000, ta};
        12'h043: inst = {12'h001, rsr};
        12'h044: inst = {12'h000, ta};
        12'h045: inst = {12'h002, rsr};
        12'h046: inst = {12'h000, ta};
        12'h047: inst = {12'h003, rsr};
        12'h048: inst = {12'h000, ta};
        12'h049: inst = {12'h0ff, tx};
        12'h04a: inst = {12'h000, ra};     // cmd17_r1, wait for zero
        12'h04b: inst = {12'h04a, jnz};
        12'h04c: inst = {12'h000, ra};     // token_wait, 0xfe
        12'h04d: inst = {12'h002, add};
        12'h04e: inst = {12'h04c, jnz};
        12'h04f: inst = {12'h200, mov};
        12'h050: inst = {12'hfff, add};    // data_loop
        12'h051: inst = {12'h000, rs};
        12'h052: inst = {12'h050, jnz};
        12'h053: inst = {12'h0ff, tx};     // crc, dropped
        12'h054: inst = {12'h0ff, tx};
        12'h055: inst = {12'h000, cs};
        12'h056: inst = {12'h0ff, tx};
        // wait for the next request
        12'h057: inst = {12'h000, hlt};
        12'h058: inst = {12'hfff, mov};
        12'h059: inst = {12'h03f, jnz};
        default: inst = {12'h000, add};
        endcase
    end

endmodule

// File: verilog/sd_sequencer.sv
module sd_sequencer (
    input  logic                      iclk,
    input  logic                      en,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  sd_link_pkg::sd_req_t      req,
    output logic                      byte_valid,
    input  logic                      byte_ready,
    output sd_link_pkg::sector_byte_t byte_out,
    output sd_isa_pkg::pc_t           pc,
    input  sd_isa_pkg::inst_t         inst,
    output sd_isa_pkg::acc_cmd_t      acc_cmd,
    input  sd_isa_pkg::acc_t          acc,
    input  logic                      acc_zero,
    input  logic                      acc_neg,
    input  sd_link_pkg::spi_byte_t    sr_rd,
    output sd_link_pkg::div_t         div,
    output logic                      tx_valid,
    input  logic                      tx_ready,
    output sd_link_pkg::spi_byte_t    tx_byte,
    input  logic                      rx_valid,
    input  sd_link_pkg::spi_byte_t    rx_byte,
    output logic                      spi_cs
);
    import sd_isa_pkg::*;
    import sd_link_pkg::*;

    typedef enum logic [1:0] {st_fetch, st_load, st_xfer, st_store} state_t;

    state_t      state;
    logic        halted;
    logic [2:0]  addr_left;     // address bytes still to copy into sr
    logic [31:0] addr_q;
    spi_byte_t   rx_q;

    // the pc holds during a transfer, so inst.op is the transfer kind
    always_ff @(posedge iclk or negedge en)
    begin
        if (!en)
        begin
            state     <= st_fetch;
            pc        <= '0;
            halted    <= 1'b0;
            addr_left <= '0;
            spi_cs    <= 1'b1;
            div       <= DIV_SLOW;
        end
        else
        begin
            case (state)
            st_fetch:
                case (inst.op)
                jnz: pc <= acc_zero ? pc + 1'b1 : inst.imm;
                js:  pc <= acc_neg ? inst.imm : pc + 1'b1;
                tx, ta, lt, ra, rs: state <= st_load;
                cs:
                begin
                    spi_cs <= ~spi_cs;
                    pc     <= pc + 1'b1;
                end
                ccd:
                begin
                    div <= DIV_FAST;
                    pc  <= pc + 1'b1;
                end
                hlt:
                    if (addr_left != 0)
                    begin
                        addr_left <= addr_left - 1'b1;
                        if (addr_left == 3'd1)
                            pc <= pc + 1'b1;    // last address byte written
                    end
                    else if (halted && req_valid)
                    begin
                        halted    <= 1'b0;
                        addr_left <= 3'd4;
                    end
                    else
                        halted <= 1'b1;
                default: pc <= pc + 1'b1;
                endcase
            st_load:
                if (tx_ready)
                    state <= st_xfer;
            st_xfer:
                if (rx_valid)
                    state <= st_store;
            st_store:
                if (inst.op != rs || byte_ready)
                begin
                    state <= st_fetch;
                    pc    <= pc + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge iclk)
    begin
        if (state == st_xfer && rx_valid)
            rx_q <= rx_byte;
        if (req_valid && req_ready)
            addr_q <= req.addr;
        else if (addr_left != 0)
            addr_q <= addr_q << 8;  // next byte to the top
    end

    assign req_ready  = halted;
    assign tx_valid   = (state == st_load);
    assign byte_valid = (state == st_store) && (inst.op == rs);
    assign byte_out   = '{idx: ~acc[8:0], data: rx_q};    // acc counts down from 0x1ff

    always_comb
    begin
        case (inst.op)
        tx:      tx_byte = inst.imm[7:0];
        ta:      tx_byte = acc[7:0];
        lt:      tx_byte = sr_rd;
        default: tx_byte = 8'hff;   // clock in a response byte
        endcase
    end

    always_comb
    begin
        acc_cmd           = '0;
        acc_cmd.ctl.op    = inst.op;
        acc_cmd.imm       = inst.imm;
        acc_cmd.load_byte = rx_q;
        if (state == st_fetch)
        begin
            acc_cmd.ctl.acc_we = inst.op inside {add, mov, stb, rsb, rsr};
            acc_cmd.ctl.sr_we  = (inst.op == wsr);
            if (inst.op == hlt && addr_left != 0)
            begin
                acc_cmd.ctl.sr_we        = 1'b1;
                acc_cmd.ctl.sr_from_load = 1'b1;
                acc_cmd.imm              = acc_t'(SR_ADDR0 + 4 - int'(addr_left));
                acc_cmd.load_byte        = addr_q[31:24];
            end
        end
        else if (state == st_store)
            acc_cmd.ctl.acc_we = (inst.op == ra);
    end

    // stream payload holds while the consumer stalls
    assert property (@(posedge iclk) disable iff (!en)
        byte_valid && !byte_ready |=> byte_valid && $stable(byte_out));

    // one byte in flight, so a new byte only ever meets an idle engine
    assert property (@(posedge iclk) disable iff (!en) tx_valid |-> tx_ready);

endmodule

// File: verilog/sd_spi_reader.sv
module sd_spi_reader (
    input  logic                      iclk,
    input  logic                      en,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  sd_link_pkg::sd_req_t      req,
    output logic                      byte_valid,
    input  logic                      byte_ready,
    output sd_link_pkg::sector_byte_t byte_out,
    output logic                      spi_cs,
    output logic                      spi_clk,
    output logic                      spi_mosi,
    input  logic                      spi_miso
);
    import sd_isa_pkg::*;
    import sd_link_pkg::*;

    pc_t       pc;
    inst_t     inst;
    acc_cmd_t  acc_cmd;
    acc_t      acc;
    logic      acc_zero;
    logic      acc_neg;
    spi_byte_t sr_rd;
    div_t      div;
    logic      tx_valid;
    logic      tx_ready;
    spi_byte_t tx_byte;
    logic      rx_valid;
    spi_byte_t rx_byte;

    sd_sequencer sd_sequencer_i (
        .iclk       (iclk),
        .en         (en),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .byte_out   (byte_out),
        .pc         (pc),
        .inst       (inst),
        .acc_cmd    (acc_cmd),
        .acc        (acc),
        .acc_zero   (acc_zero),
        .acc_neg    (acc_neg),
        .sr_rd      (sr_rd),
        .div        (div),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_byte    (tx_byte),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .spi_cs     (spi_cs)
    );

    sd_microcode_rom sd_microcode_rom_i (
        .addr (pc),
        .inst (inst)
    );

    sd_accumulator sd_accumulator_i (
        .iclk      (iclk),
        .en        (en),
        .acc_cmd   (acc_cmd.ctl),
        .imm       (acc_cmd.imm),
        .load_byte (acc_cmd.load_byte),
        .acc       (acc),
        .acc_zero  (acc_zero),
        .acc_neg   (acc_neg),
        .sr_rd     (sr_rd)
    );

    spi_byte_engine spi_byte_engine_i (
        .iclk     (iclk),
        .en       (en),
        .div      (div),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_byte  (tx_byte),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

endmodule

// File: verilog/spi_byte_engine.sv
module spi_byte_engine (
    input  logic                   iclk,
    input  logic                   en,
    input  sd_link_pkg::div_t      div,
    input  logic                   tx_valid,
    output logic                   tx_ready,
    input  sd_link_pkg::spi_byte_t tx_byte,
    output logic                   rx_valid,
    output sd_link_pkg::spi_byte_t rx_byte,
    output logic                   spi_clk,
    output logic                   spi_mosi,
    input  logic                   spi_miso
);
    import sd_link_pkg::*;

    div_t       half_cnt;
    logic       busy;
    logic [2:0] bit_cnt;
    spi_byte_t  tx_sh;
    logic       tick;

    assign tick     = busy && (half_cnt == div);   // end of a half period
    assign tx_ready = !busy;

    always_ff @(posedge iclk or negedge en)
    begin
        if (!en)
        begin
            busy     <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            spi_clk  <= 1'b0;
            spi_mosi <= 1'b1;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            if (!busy)
            begin
                if (tx_valid)
                begin
                    busy     <= 1'b1;
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                    spi_mosi <= tx_byte[7];   // msb out before first rise
                end
            end
            else if (!tick)
                half_cnt <= half_cnt + 1'b1;
            else
            begin
                half_cnt <= '0;
                spi_clk  <= ~spi_clk;
                if (spi_clk)
                begin
                    if (bit_cnt == 3'd7)
                    begin
                        busy     <= 1'b0;
                        rx_valid <= 1'b1;
                        spi_mosi <= 1'b1;     // idle high
                    end
                    else
                    begin
                        bit_cnt  <= bit_cnt + 1'b1;
                        spi_mosi <= tx_sh[6];
                    end
                end
            end
        end
    end

    always_ff @(posedge iclk)
    begin
        if (!busy && tx_valid)
            tx_sh <= tx_byte;
        else if (tick && spi_clk)
            tx_sh <= tx_sh << 1;
        if (tick && !spi_clk)
            rx_byte <= {rx_byte[6:0], spi_miso};    // sample on rising edge
    end

    // mode 0, the clock rests low between bytes
    assert property (@(posedge iclk) disable iff (!en) tx_ready |-> !spi_clk);

endmodule
